//--- src/copper_isa_pkg.sv
package copper_isa_pkg;

    // field widths of a copper instruction word
    localparam int COPP_WORD_W    = 16;
    localparam int COPP_OP_W      = 4;
    localparam int COPP_OPERAND_W = COPP_WORD_W - COPP_OP_W;
    // a MOVE names its target in the low bits of the operand
    localparam int COPP_REG_W     = 4;

    // one program word as stored in program memory
    typedef logic [COPP_WORD_W-1:0] copp_word_t;

    // operand field below the opcode nibble
    typedef logic [COPP_OPERAND_W-1:0] copp_operand_t;

    // opcode in the top nibble
    // codes not listed here execute as a no-op
    typedef enum logic [COPP_OP_W-1:0] {
        WAIT_H = 4'd1,
        WAIT_V = 4'd2,
        MOVE   = 4'd4,
        JUMP   = 4'd8
    } copp_op_e;

    // decoded view of a program word
    typedef struct packed {
        copp_op_e      op;
        copp_operand_t operand;
    } copp_instr_t;

    // wait on vpos 4095, never reached by the beam
    // so this parks the program until the next frame start
    localparam copp_word_t COPP_HALT_WORD = 16'h2FFF;

endpackage

//--- src/copper_bus_pkg.sv
package copper_bus_pkg;

    // host register select
    typedef enum logic [1:0] {
        CTRL = 2'd0,
        ADDR = 2'd1,
        DATA = 2'd2
    } host_sel_e;

    // run enable position inside the CTRL register
    localparam int CTRL_RUN_BIT = 0;

    // host write data, same width as a program word
    typedef logic [15:0] host_data_t;

    // single-cycle host write
    typedef struct packed {
        logic       wr;
        host_sel_e  sel;
        host_data_t data;
    } host_wr_t;

    // beam counter value, used for hpos and vpos
    typedef logic [11:0] beam_pos_t;

    // display register bank
    localparam int DISP_REG_COUNT = 16;
    typedef logic [3:0]  disp_addr_t;
    typedef logic [15:0] disp_word_t;

    // one register write issued by the executor
    typedef struct packed {
        logic       wr;
        disp_addr_t addr;
        disp_word_t data;
    } disp_wr_t;

endpackage

//--- src/copper_host_port.sv
module copper_host_port #(
    parameter int PROG_AWIDTH = 10
) (
    input  logic                        clk,
    input  logic                        rst_n_i,
    input  copper_bus_pkg::host_wr_t    host_i,
    output logic                        mem_wr_en_o,
    output logic [PROG_AWIDTH-1:0]      mem_wr_addr_o,
    output copper_isa_pkg::copp_word_t  mem_wr_data_o,
    output logic                        run_en_o
);

    typedef logic [PROG_AWIDTH-1:0] ptr_t;

    logic ctrl_wr;
    logic addr_wr;
    logic data_wr;
    logic run_q;
    logic wr_en_q;
    ptr_t wr_ptr_q;
    copper_isa_pkg::copp_word_t wr_data_q;

    // host strobe split per register
    assign ctrl_wr = host_i.wr && (host_i.sel == copper_bus_pkg::CTRL);
    assign addr_wr = host_i.wr && (host_i.sel == copper_bus_pkg::ADDR);
    assign data_wr = host_i.wr && (host_i.sel == copper_bus_pkg::DATA);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            run_q    <= 1'b0;
            wr_en_q  <= 1'b0;
            wr_ptr_q <= '0;
        end else begin
            // memory write goes out one edge after the DATA strobe
            wr_en_q <= data_wr;
            // an ADDR write overrides the pending increment
            if (addr_wr) begin
                wr_ptr_q <= ptr_t'(host_i.data);
            end else if (wr_en_q) begin
                // bump together with the memory write, wraps at memory size
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (ctrl_wr) begin
                run_q <= host_i.data[copper_bus_pkg::CTRL_RUN_BIT];
            end
        end
    end

    // write data only
    always_ff @(posedge clk) begin
        if (data_wr) begin
            wr_data_q <= host_i.data;
        end
    end

    // pointer feeds the memory directly so back-to-back DATA writes
    // land on consecutive words
    assign mem_wr_en_o   = wr_en_q;
    assign mem_wr_addr_o = wr_ptr_q;
    assign mem_wr_data_o = wr_data_q;
    assign run_en_o      = run_q;

endmodule

//--- src/copper_mem.sv
module copper_mem #(
    parameter int PROG_AWIDTH = 10
) (
    input  logic                        clk,
    input  logic                        wr_en_i,
    input  logic [PROG_AWIDTH-1:0]      wr_addr_i,
    input  copper_isa_pkg::copp_word_t  wr_data_i,
    input  logic [PROG_AWIDTH-1:0]      rd_addr_i,
    output copper_isa_pkg::copp_word_t  rd_data_o
);

    localparam int DEPTH = 2 ** PROG_AWIDTH;

    // program storage, inferred as block RAM
    copper_isa_pkg::copp_word_t bram [DEPTH];

    logic same_addr;

    // every word starts as the halt instruction
    // so an unloaded program waits out the frame
    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            bram[i] = copper_isa_pkg::COPP_HALT_WORD;
        end
    end

    // write port
    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            bram[wr_addr_i] <= wr_data_i;
        end
    end

    assign same_addr = wr_en_i && (rd_addr_i == wr_addr_i);

    // registered read port
    // read during write to the same word returns the new data
    always_ff @(posedge clk) begin
        if (same_addr) begin
            rd_data_o <= wr_data_i;
        end else begin
            rd_data_o <= bram[rd_addr_i];
        end
    end

endmodule

//--- src/copper_exec.sv
module copper_exec #(
    parameter int PROG_AWIDTH = 10
) (
    input  logic                        clk,
    input  logic                        rst_n_i,
    input  logic                        run_en_i,
    input  logic                        frame_start_i,
    input  copper_bus_pkg::beam_pos_t   vpos_i,
    input  copper_bus_pkg::beam_pos_t   hpos_i,
    output logic [PROG_AWIDTH-1:0]      mem_rd_addr_o,
    input  copper_isa_pkg::copp_word_t  mem_rd_data_i,
    output copper_bus_pkg::disp_wr_t    disp_wr_o
);

    typedef logic [PROG_AWIDTH-1:0] pc_t;

    typedef enum logic [2:0] {
        IDLE,
        FETCH,
        DECODE,
        WAIT_BEAM,
        MOVE_DATA,
        MOVE_WRITE
    } exec_state_e;

    exec_state_e state_q;
    exec_state_e state_d;
    pc_t pc_q;
    copper_isa_pkg::copp_instr_t instr;
    copper_isa_pkg::copp_operand_t operand_q;
    logic wait_vert_q;
    logic beam_hit;
    logic restart;
    logic wr_strobe_q;
    copper_bus_pkg::disp_addr_t wr_addr_q;
    copper_bus_pkg::disp_word_t wr_data_q;

    // memory output is only meaningful as an instruction in DECODE
    assign instr = copper_isa_pkg::copp_instr_t'(mem_rd_data_i);

    // run level is sampled only at frame start
    assign restart = frame_start_i && run_en_i;

    // wait is done once the beam is at or past the operand
    assign beam_hit = wait_vert_q ? (vpos_i >= operand_q) : (hpos_i >= operand_q);

    // pc addresses the instruction in FETCH and the data word in DECODE
    assign mem_rd_addr_o = pc_q;

    always_comb begin
        state_d = state_q;
        if (frame_start_i) begin
            // frame start aborts whatever is in flight
            state_d = run_en_i ? FETCH : IDLE;
        end else begin
            case (state_q)
                IDLE: begin
                    state_d = IDLE;
                end
                FETCH: begin
                    state_d = DECODE;
                end
                DECODE: begin
                    case (instr.op)
                        copper_isa_pkg::WAIT_H,
                        copper_isa_pkg::WAIT_V: state_d = WAIT_BEAM;
                        copper_isa_pkg::MOVE:   state_d = MOVE_DATA;
                        // jump and no-op go straight to the next fetch
                        default:                state_d = FETCH;
                    endcase
                end
                WAIT_BEAM: begin
                    if (beam_hit) begin
                        state_d = FETCH;
                    end
                end
                MOVE_DATA: begin
                    state_d = MOVE_WRITE;
                end
                MOVE_WRITE: begin
                    state_d = FETCH;
                end
                default: begin
                    state_d = IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q     <= IDLE;
            pc_q        <= '0;
            wr_strobe_q <= 1'b0;
        end else begin
            state_q     <= state_d;
            // one pulse per MOVE, in the cycle after the data word
            wr_strobe_q <= (state_d == MOVE_WRITE);
            if (restart) begin
                pc_q <= '0;
            end else if (state_q == FETCH) begin
                pc_q <= pc_q + 1'b1;
            end else if (state_q == DECODE) begin
                if (instr.op == copper_isa_pkg::JUMP) begin
                    // target truncated to the program address width
                    pc_q <= pc_t'(instr.operand);
                end else if (instr.op == copper_isa_pkg::MOVE) begin
                    // step over the data word
                    pc_q <= pc_q + 1'b1;
                end
            end
        end
    end

    // operand and move payload
    always_ff @(posedge clk) begin
        if (state_q == DECODE) begin
            operand_q   <= instr.operand;
            wait_vert_q <= (instr.op == copper_isa_pkg::WAIT_V);
            wr_addr_q   <= instr.operand[copper_isa_pkg::COPP_REG_W-1:0];
        end
        if (state_q == MOVE_DATA) begin
            wr_data_q <= mem_rd_data_i;
        end
    end

    assign disp_wr_o = '{wr: wr_strobe_q, addr: wr_addr_q, data: wr_data_q};

endmodule

//--- src/copper_disp_regs.sv
module copper_disp_regs (
    input  logic                        clk,
    input  logic                        rst_n_i,
    input  copper_bus_pkg::disp_wr_t    disp_wr_i,
    input  copper_bus_pkg::disp_addr_t  rd_addr_i,
    output copper_bus_pkg::disp_word_t  rd_data_o
);

    // display control registers
    copper_bus_pkg::disp_word_t regs_q [copper_bus_pkg::DISP_REG_COUNT];

    // written only by copper moves
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < copper_bus_pkg::DISP_REG_COUNT; i++) begin
                regs_q[i] <= '0;
            end
        end else if (disp_wr_i.wr) begin
            regs_q[disp_wr_i.addr] <= disp_wr_i.data;
        end
    end

    // host readback is combinational
    // a move is visible right after its write edge
    assign rd_data_o = regs_q[rd_addr_i];

endmodule

//--- src/copper_top.sv
module copper_top #(
    parameter int PROG_AWIDTH = 10
) (
    input  logic                        clk,
    input  logic                        rst_n_i,
    input  copper_bus_pkg::host_wr_t    host_i,
    input  logic                        frame_start_i,
    input  copper_bus_pkg::beam_pos_t   vpos_i,
    input  copper_bus_pkg::beam_pos_t   hpos_i,
    input  copper_bus_pkg::disp_addr_t  disp_rd_addr_i,
    output copper_bus_pkg::disp_word_t  disp_rd_data_o
);

    // host port to program memory
    logic                       mem_wr_en;
    logic [PROG_AWIDTH-1:0]     mem_wr_addr;
    copper_isa_pkg::copp_word_t mem_wr_data;

    // executor fetch path
    logic [PROG_AWIDTH-1:0]     mem_rd_addr;
    copper_isa_pkg::copp_word_t mem_rd_data;

    logic                       run_en;
    copper_bus_pkg::disp_wr_t   disp_wr;

    copper_host_port #(
        .PROG_AWIDTH   (PROG_AWIDTH)
    ) u_host_port (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .host_i        (host_i),
        .mem_wr_en_o   (mem_wr_en),
        .mem_wr_addr_o (mem_wr_addr),
        .mem_wr_data_o (mem_wr_data),
        .run_en_o      (run_en)
    );

    copper_mem #(
        .PROG_AWIDTH   (PROG_AWIDTH)
    ) u_mem (
        .clk           (clk),
        .wr_en_i       (mem_wr_en),
        .wr_addr_i     (mem_wr_addr),
        .wr_data_i     (mem_wr_data),
        .rd_addr_i     (mem_rd_addr),
        .rd_data_o     (mem_rd_data)
    );

    copper_exec #(
        .PROG_AWIDTH   (PROG_AWIDTH)
    ) u_exec (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .run_en_i      (run_en),
        .frame_start_i (frame_start_i),
        .vpos_i        (vpos_i),
        .hpos_i        (hpos_i),
        .mem_rd_addr_o (mem_rd_addr),
        .mem_rd_data_i (mem_rd_data),
        .disp_wr_o     (disp_wr)
    );

    copper_disp_regs u_disp_regs (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .disp_wr_i     (disp_wr),
        .rd_addr_i     (disp_rd_addr_i),
        .rd_data_o     (disp_rd_data_o)
    );

endmodule

//--- test/tb_clock_gen.sv
module tb_clock_gen #(
    parameter int HALF_PERIOD = 2
) (
    output logic clk
);

    // free-running clock, period 4
    initial begin
        clk = 1'b0;
    end

    always begin
        #HALF_PERIOD clk = ~clk;
    end

endmodule

//--- test/copper_sva.sv
module copper_sva #(
    parameter int PROG_AWIDTH = 10
) (
    input logic                       clk,
    input logic                       rst_n_i,
    input logic                       run_en_i,
    input copper_bus_pkg::disp_wr_t   disp_wr_i,
    input logic [PROG_AWIDTH-1:0]     rd_addr_i
);

    // number of failed assertions in this instance
    int fail_cnt = 0;

    // one register write per MOVE, never two in a row
    assert property (@(posedge clk) disable iff (!rst_n_i)
        disp_wr_i.wr |=> !disp_wr_i.wr)
        else begin
            fail_cnt++;
            $error("display write strobe longer than one cycle");
        end

    // an unknown fetch address would read outside the program memory
    assert property (@(posedge clk) disable iff (!rst_n_i)
        !$isunknown(rd_addr_i))
        else begin
            fail_cnt++;
            $error("program read address outside memory");
        end

    // register writes only while run is enabled
    assert property (@(posedge clk) disable iff (!rst_n_i)
        disp_wr_i.wr |-> run_en_i)
        else begin
            fail_cnt++;
            $error("display write while run disabled");
        end

endmodule

bind copper_exec copper_sva #(.PROG_AWIDTH(PROG_AWIDTH)) u_exec_sva (
    .clk       (clk),
    .rst_n_i   (rst_n_i),
    .run_en_i  (run_en_i),
    .disp_wr_i (disp_wr_o),
    .rd_addr_i (mem_rd_addr_o)
);

// memory side has no reset or strobe, only its read address is checked
bind copper_mem copper_sva #(.PROG_AWIDTH(PROG_AWIDTH)) u_mem_sva (
    .clk       (clk),
    .rst_n_i   (1'b1),
    .run_en_i  (1'b1),
    .disp_wr_i ('0),
    .rd_addr_i (rd_addr_i)
);

//--- test/tb_copper_top.sv
module tb_copper_top;

    localparam int PROG_AWIDTH = 10;
    localparam int DEPTH = 2 ** PROG_AWIDTH;
    localparam logic [15:0] HALT = 16'h2FFF;

    typedef copper_isa_pkg::copp_word_t img_t [DEPTH];
    typedef copper_bus_pkg::disp_word_t bank_t [16];

    logic clk;
    logic rst_n_i;
    copper_bus_pkg::host_wr_t host_i;
    logic frame_start_i;
    copper_bus_pkg::beam_pos_t vpos_i;
    copper_bus_pkg::beam_pos_t hpos_i;
    copper_bus_pkg::disp_addr_t disp_rd_addr_i;
    copper_bus_pkg::disp_word_t disp_rd_data_o;

    img_t prog_img;
    bank_t base_bank;
    bank_t exp_bank;
    copper_isa_pkg::copp_word_t prog_q[$];
    integer seed;
    int checks_done;
    event check_req;

    tb_clock_gen u_clk (.clk(clk));

    copper_top #(.PROG_AWIDTH(PROG_AWIDTH)) u_copper_top (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .host_i         (host_i),
        .frame_start_i  (frame_start_i),
        .vpos_i         (vpos_i),
        .hpos_i         (hpos_i),
        .disp_rd_addr_i (disp_rd_addr_i),
        .disp_rd_data_o (disp_rd_data_o)
    );

    task automatic fail_stop(input string why);
        $display("%s", why);
        $display("Finished with errors");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input copper_bus_pkg::disp_word_t got,
                              input copper_bus_pkg::disp_word_t exp);
        if (got !== exp) begin
            fail_stop($sformatf("error: time %0t %s got %h expected %h", $time, name, got, exp));
        end
    endtask

    task automatic check_pos(input string name, input copper_bus_pkg::beam_pos_t got,
                             input copper_bus_pkg::beam_pos_t exp);
        if (got !== exp) begin
            fail_stop($sformatf("error: time %0t %s got %0d expected %0d", $time, name, got, exp));
        end
    endtask

    // failures counted by the bound checkers
    function automatic int bound_failures();
        return u_copper_top.u_exec.u_exec_sva.fail_cnt +
               u_copper_top.u_mem.u_mem_sva.fail_cnt;
    endfunction

    // expected bank after the program has run up to beam (v,h)
    // cursor (cv,ch) is the earliest beam position that passes all waits so far
    function automatic void ref_bank(input img_t img, input bank_t start,
                                     input copper_bus_pkg::beam_pos_t v,
                                     input copper_bus_pkg::beam_pos_t h, output bank_t res);
        logic [PROG_AWIDTH-1:0] pc;
        logic [15:0] w;
        logic [11:0] opd;
        int cv;
        int ch;
        bit blocked;
        res = start;
        pc = '0;
        cv = 0;
        ch = 0;
        blocked = 1'b0;
        for (int steps = 0; steps < 512 && !blocked; steps++) begin
            w = img[pc];
            opd = w[11:0];
            case (w[15:12])
                4'd1, 4'd2: begin
                    if (w[15:12] == 4'd2 && opd > cv) begin
                        cv = opd;
                        ch = 0;
                    end else if (w[15:12] == 4'd1 && opd > ch) begin
                        ch = opd;
                    end
                    // hpos never passes 99 and vpos never passes 59
                    if (ch > 99 || cv > 59 || cv > v || (cv == v && ch > h)) begin
                        blocked = 1'b1;
                    end
                    pc = pc + 1'b1;
                end
                4'd4: begin
                    res[opd[3:0]] = img[pc + 1'b1];
                    pc = pc + 2'd2;
                end
                4'd8: pc = opd[PROG_AWIDTH-1:0];
                default: pc = pc + 1'b1;
            endcase
        end
    endfunction

    task automatic host_write(input copper_bus_pkg::host_sel_e sel, input logic [15:0] data);
        @(posedge clk);
        #1 host_i = '{wr: 1'b1, sel: sel, data: data};
        @(posedge clk);
        #1 host_i.wr = 1'b0;
    endtask

    task automatic load_prog(input int base);
        host_write(copper_bus_pkg::ADDR, 16'(base));
        foreach (prog_q[i]) begin
            host_write(copper_bus_pkg::DATA, prog_q[i]);
            prog_img[(base + i) % DEPTH] = prog_q[i];
        end
        prog_q.delete();
    endtask

    task automatic push_move(input logic [3:0] r, input logic [15:0] d);
        prog_q.push_back({4'd4, 8'd0, r});
        prog_q.push_back(d);
    endtask

    task automatic push_random_moves(input int n);
        for (int i = 0; i < n; i++) begin
            push_move(4'($random(seed)), 16'($random(seed)));
        end
    endtask

    task automatic wait_beam(input int v, input int h);
        int cnt;
        cnt = 0;
        while (!(vpos_i == v && hpos_i == h)) begin
            @(posedge clk);
            cnt++;
            if (cnt > 7000) begin
                fail_stop($sformatf("beam position %0d,%0d was never reached", v, h));
            end
        end
    endtask

    // poll one register until it holds d, then compare the beam position
    task automatic find_move_pos(input copper_bus_pkg::disp_addr_t r,
                                 input copper_bus_pkg::disp_word_t d,
                                 input int v, input int h);
        int cnt;
        cnt = 0;
        @(posedge clk);
        #1 disp_rd_addr_i = r;
        #1;
        while (disp_rd_data_o !== d) begin
            @(posedge clk);
            #2;
            cnt++;
            if (cnt > 200) begin
                fail_stop($sformatf("register %0d never took the value %h", r, d));
            end
        end
        check_pos("vpos_i", vpos_i, 12'(v));
        check_pos("hpos_i", hpos_i, 12'(h));
    endtask

    // read the whole bank at beam (v,h)
    task automatic run_check(input int v, input int h, input bit use_ref);
        int cnt;
        int start;
        wait_beam(v, h);
        if (use_ref) begin
            ref_bank(prog_img, base_bank, 12'(v), 12'(h), exp_bank);
        end else begin
            exp_bank = base_bank;
        end
        start = checks_done;
        -> check_req;
        cnt = 0;
        while (checks_done == start) begin
            @(posedge clk);
            cnt++;
            if (cnt > 100) begin
                fail_stop("register readback did not complete");
            end
        end
    endtask

    // compare process, walks the host read port
    initial begin
        forever begin
            @(check_req);
            for (int i = 0; i < 16; i++) begin
                @(posedge clk);
                #1 disp_rd_addr_i = 4'(i);
                #1 check_word($sformatf("disp_reg[%0d]", i), disp_rd_data_o, exp_bank[i]);
            end
            checks_done++;
        end
    end

    // stop as soon as a bound assertion has failed
    always @(negedge clk) begin
        if (bound_failures() != 0) begin
            fail_stop("a bound assertion failed");
        end
    end

    // beam model, 100 x 60, frame start at (0,0)
    initial begin
        wait (rst_n_i === 1'b1);
        forever begin
            @(posedge clk);
            #1;
            if (hpos_i == 99) begin
                hpos_i = 0;
                vpos_i = (vpos_i == 59) ? 12'd0 : vpos_i + 1'b1;
            end else begin
                hpos_i = hpos_i + 1'b1;
            end
            frame_start_i = (hpos_i == 0 && vpos_i == 0);
        end
    end

    initial begin
        seed = 32'ha2a81da2;
        host_i = '0;
        frame_start_i = 1'b0;
        vpos_i = 12'd59;
        hpos_i = 12'd99;
        disp_rd_addr_i = '0;
        checks_done = 0;
        rst_n_i = 1'b0;
        for (int i = 0; i < DEPTH; i++) begin
            prog_img[i] = HALT;
        end
        for (int i = 0; i < 16; i++) begin
            base_bank[i] = '0;
        end
        repeat (8) @(posedge clk);
        #1 rst_n_i = 1'b1;

        // run starts with the next frame and the unloaded memory halts at once
        host_write(copper_bus_pkg::CTRL, 16'h0001);
        wait_beam(58, 0);
        run_check(57, 50, 1'b1);

        // random moves, repeated registers keep the last one
        wait_beam(58, 0);
        push_random_moves(12);
        prog_q.push_back(HALT);
        load_prog(0);
        run_check(57, 50, 1'b1);
        base_bank = exp_bank;

        // moves behind a wait on (30,50)
        wait_beam(58, 0);
        push_random_moves(1);
        prog_q.push_back(16'h201E);
        prog_q.push_back(16'h1032);
        push_move(4'd15, 16'hC0DE);
        push_random_moves(5);
        prog_q.push_back(HALT);
        load_prog(0);
        run_check(30, 20, 1'b1);
        // wait ends one cycle after hpos reaches 50
        // then the MOVE needs four cycles up to its write edge
        find_move_pos(4'd15, 16'hC0DE, 30, 50 + 5);
        run_check(57, 50, 1'b1);
        base_bank = exp_bank;

        // jump over the move to register 2
        wait_beam(58, 0);
        push_move(4'd1, 16'($random(seed)));
        prog_q.push_back(16'h8005);
        push_move(4'd2, 16'($random(seed)));
        push_move(4'd3, 16'($random(seed)));
        prog_q.push_back(HALT);
        load_prog(0);
        run_check(57, 50, 1'b1);
        base_bank = exp_bank;

        // run disabled, new program waits for the enable
        wait_beam(58, 0);
        host_write(copper_bus_pkg::CTRL, 16'h0000);
        push_random_moves(8);
        prog_q.push_back(HALT);
        load_prog(0);
        run_check(57, 50, 1'b0);
        wait_beam(58, 0);
        host_write(copper_bus_pkg::CTRL, 16'h0001);
        run_check(57, 50, 1'b1);
        base_bank = exp_bank;

        // program at 0x200 reached by a jump
        wait_beam(58, 0);
        prog_q.push_back(16'h8200);
        load_prog(0);
        push_random_moves(6);
        prog_q.push_back(HALT);
        load_prog(12'h200);
        run_check(57, 50, 1'b1);
        base_bank = exp_bank;

        #1;
        if (bound_failures() != 0) begin
            fail_stop("a bound assertion failed");
        end else begin
            $display("Finished with no errors");
            $finish;
        end
    end

endmodule

//--- copper_top.f
src/copper_isa_pkg.sv
src/copper_bus_pkg.sv
src/copper_host_port.sv
src/copper_mem.sv
src/copper_exec.sv
src/copper_disp_regs.sv
src/copper_top.sv
test/tb_clock_gen.sv
test/copper_sva.sv
test/tb_copper_top.sv
